//--- all.f
+incdir+hw
hw/core_pkg.sv
hw/mem_port_if.sv
hw/unified_ram.sv
hw/mem_arbiter.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/core_top.sv
tests/core_sva.sv
tests/core_tb.sv

//--- hw/core_params.svh
/* Core sizing. Memory is word addressed with 2^MEM_AW words shared by code and data.
   The reset PC must fall inside that memory. */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

////////////////////
// Datapath widths
////////////////////
`define DATA_W 32 // Data and instruction width
`define REG_AW 5 // 32 architectural registers

////////////////////
// Memory and PC
////////////////////
`define MEM_AW 8 // Word address bits into the unified RAM
`define MEM_DEPTH (1 << `MEM_AW) // 256 words
`define RESET_PC 32'h0000_0000 // Byte address of the first fetch

`endif

//--- hw/core_pkg.sv
/* Shared types for the MIPS-subset pipeline. Only ADDU SUBU AND OR SLT ADDIU ORI LW SW BEQ BNE J
   are decoded, so the control fields below cover just those. */
`default_nettype none
`include "core_params.svh"

package core_pkg;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`MEM_AW-1:0] mem_addr_t;
    typedef logic [`REG_AW-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // Owner of the RAM port this cycle
    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_LOADER,
        GNT_DATA,
        GNT_FETCH
    } grant_e;

    ////////////////////
    // Pipeline registers
    ////////////////////
    typedef struct packed {
        logic        valid;
        word_t       pc_plus4;
        word_t       op_a; // rs value from the register file
        word_t       op_b; // rt value from the register file
        reg_idx_t    rs;
        reg_idx_t    rt;
        word_t       imm; // Already sign or zero extended
        logic [25:0] jtarget;
        alu_op_e     alu_op;
        logic        use_imm;
        logic        is_load;
        logic        is_store;
        logic        is_branch;
        logic        branch_ne; // BNE when set, BEQ otherwise
        logic        is_jump;
        reg_idx_t    dest;
        logic        writes_reg;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    result; // ALU result, or byte address for LW/SW
        word_t    store_data;
        reg_idx_t dest;
        logic     writes_reg;
        logic     is_load;
        logic     is_store;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    wdata;
        reg_idx_t dest;
        logic     writes_reg;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- hw/core_top.sv
/* Five-stage core on one shared RAM. Keep run low while loading through load_en;
   the commit trace has no back-pressure. */
`default_nettype none

module core_top import core_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            run,
    input  wire            load_en,
    input  wire mem_addr_t load_addr,
    input  wire word_t     load_data,
    output logic           commit_valid,
    output reg_idx_t       commit_reg,
    output word_t          commit_data
);

    mem_port_if fetch_port ();
    mem_port_if data_port ();

    mem_addr_t ram_addr;
    logic      ram_we;
    word_t     ram_wdata, ram_rdata;
    logic      hold, redirect, ifid_valid;
    word_t     redirect_pc, ifid_insn, ifid_pc4;
    id_ex_t    idex;
    ex_mem_t   exmem;
    mem_wb_t   wb;

    ////////////////////
    // Memory side
    ////////////////////
    unified_ram ram_i (
        .clk(clk), .addr(ram_addr), .we(ram_we), .wdata(ram_wdata), .rdata(ram_rdata)
    );

    mem_arbiter arb_i (
        .clk(clk), .rst(rst), .fetch(fetch_port.arbiter), .data(data_port.arbiter),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .ram_addr(ram_addr), .ram_we(ram_we), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
    );

    ////////////////////
    // Pipeline
    ////////////////////
    fetch_stage fetch_i (
        .clk(clk), .rst(rst), .run(run), .hold(hold), .redirect(redirect),
        .redirect_pc(redirect_pc), .port(fetch_port.requester),
        .ifid_valid(ifid_valid), .ifid_insn(ifid_insn), .ifid_pc4(ifid_pc4)
    );

    decode_stage decode_i (
        .clk(clk), .rst(rst), .run(run), .ifid_valid(ifid_valid), .ifid_insn(ifid_insn),
        .ifid_pc4(ifid_pc4), .flush(redirect), .wb(wb), .ex_dest(idex.dest),
        .ex_is_load(idex.valid & idex.is_load), .hold(hold), .idex(idex)
    );

    execute_stage execute_i (
        .clk(clk), .rst(rst), .run(run), .idex(idex), .mem_fwd(exmem), .wb_fwd(wb),
        .redirect(redirect), .redirect_pc(redirect_pc), .exmem(exmem)
    );

    mem_wb_stage mem_wb_i (
        .clk(clk), .rst(rst), .run(run), .exmem(exmem), .port(data_port.requester),
        .wb(wb), .commit_valid(commit_valid), .commit_reg(commit_reg),
        .commit_data(commit_data)
    );

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
/* Decoder, register file and load-use detection. Unknown opcodes pass as no-ops;
   the rs/rt hazard compare is conservative and may stall on fields that are not sources. */
`default_nettype none

module decode_stage import core_pkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire           run,
    input  wire           ifid_valid,
    input  wire word_t    ifid_insn,
    input  wire word_t    ifid_pc4,
    input  wire           flush, // Redirect from execute
    input  wire mem_wb_t  wb,
    input  wire reg_idx_t ex_dest,
    input  wire           ex_is_load, // Valid load sits in execute
    output logic          hold,
    output id_ex_t        idex
);

    word_t    regs [32];
    logic     rf_we;
    logic     [5:0] opcode;
    logic     [5:0] funct;
    reg_idx_t rs, rt, rd;
    id_ex_t   dec;

    assign opcode = ifid_insn[31:26];
    assign funct  = ifid_insn[5:0];
    assign rs     = ifid_insn[25:21];
    assign rt     = ifid_insn[20:16];
    assign rd     = ifid_insn[15:11];

    ////////////////////
    // Register file
    ////////////////////
    assign rf_we = run & wb.valid & wb.writes_reg & (wb.dest != '0);

    always_ff @(posedge clk) begin
        if (rf_we) begin
            regs[wb.dest] <= wb.wdata;
        end
    end

    // r0 reads zero, same-cycle write passes through
    function automatic word_t rf_read(reg_idx_t idx);
        if (idx == '0)                       return '0;
        else if (rf_we && (wb.dest == idx))  return wb.wdata;
        else                                 return regs[idx];
    endfunction

    // Consumer right behind a load waits one cycle
    assign hold = ifid_valid & ex_is_load & (ex_dest != '0) &
                  ((ex_dest == rs) | (ex_dest == rt));

    ////////////////////
    // Decoder
    ////////////////////
    always_comb begin
        dec          = '0;
        dec.valid    = ifid_valid & ~hold & ~flush; // Bubble on stall or flush
        dec.pc_plus4 = ifid_pc4;
        dec.op_a     = rf_read(rs);
        dec.op_b     = rf_read(rt);
        dec.rs       = rs;
        dec.rt       = rt;
        dec.imm      = {{16{ifid_insn[15]}}, ifid_insn[15:0]}; // Sign extend by default
        dec.jtarget  = ifid_insn[25:0];
        dec.alu_op   = ALU_ADD;
        dec.dest     = rt; // I-type writes rt
        case (opcode)
            6'h00: begin // SPECIAL
                dec.dest       = rd;
                dec.writes_reg = 1'b1;
                case (funct)
                    6'h21:   dec.alu_op = ALU_ADD; // ADDU
                    6'h23:   dec.alu_op = ALU_SUB; // SUBU
                    6'h24:   dec.alu_op = ALU_AND;
                    6'h25:   dec.alu_op = ALU_OR;
                    6'h2a:   dec.alu_op = ALU_SLT;
                    default: dec.writes_reg = 1'b0; // Unsupported funct is a no-op
                endcase
            end
            6'h09: begin // ADDIU
                dec.use_imm    = 1'b1;
                dec.writes_reg = 1'b1;
            end
            6'h0d: begin // ORI zero extends
                dec.imm        = {16'h0000, ifid_insn[15:0]};
                dec.alu_op     = ALU_OR;
                dec.use_imm    = 1'b1;
                dec.writes_reg = 1'b1;
            end
            6'h23: begin // LW
                dec.use_imm    = 1'b1;
                dec.is_load    = 1'b1;
                dec.writes_reg = 1'b1;
            end
            6'h2b: begin // SW
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
            end
            6'h04, 6'h05: begin // BEQ, BNE
                dec.is_branch = 1'b1;
                dec.branch_ne = opcode[0];
            end
            6'h02:   dec.is_jump = 1'b1; // J
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)      idex.valid <= 1'b0;
        else if (run) idex <= dec;
    end

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
/* Bypass muxes, ALU and branch resolution. Memory-stage forwarding skips loads, which the
   decode stall keeps from being needed; all redirects start here. */
`default_nettype none
`include "core_params.svh"

module execute_stage import core_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          run,
    input  wire id_ex_t  idex,
    input  wire ex_mem_t mem_fwd,
    input  wire mem_wb_t wb_fwd,
    output logic         redirect,
    output word_t        redirect_pc,
    output ex_mem_t      exmem
);

    word_t a_val, b_val; // After bypass
    word_t alu_b;
    word_t alu_y;
    word_t br_target, j_target;
    logic  taken;

    // Younger producer first
    function automatic word_t fwd(reg_idx_t src, word_t rf_val);
        if (mem_fwd.valid && mem_fwd.writes_reg && !mem_fwd.is_load &&
            (mem_fwd.dest != '0) && (mem_fwd.dest == src)) begin
            return mem_fwd.result;
        end else if (wb_fwd.valid && wb_fwd.writes_reg &&
                     (wb_fwd.dest != '0) && (wb_fwd.dest == src)) begin
            return wb_fwd.wdata;
        end
        return rf_val;
    endfunction

    always_comb begin
        a_val = fwd(idex.rs, idex.op_a);
        b_val = fwd(idex.rt, idex.op_b);
    end

    assign alu_b = idex.use_imm ? idex.imm : b_val;

    always_comb begin
        case (idex.alu_op)
            ALU_SUB: alu_y = a_val - alu_b;
            ALU_AND: alu_y = a_val & alu_b;
            ALU_OR:  alu_y = a_val | alu_b;
            ALU_SLT: alu_y = {{(`DATA_W-1){1'b0}}, $signed(a_val) < $signed(alu_b)};
            default: alu_y = a_val + alu_b;
        endcase
    end

    ////////////////////
    // Branch and jump
    ////////////////////
    assign br_target   = idex.pc_plus4 + {idex.imm[`DATA_W-3:0], 2'b00};
    assign j_target    = {idex.pc_plus4[`DATA_W-1:28], idex.jtarget, 2'b00};
    assign taken       = idex.is_branch & ((a_val == b_val) ^ idex.branch_ne);
    assign redirect    = idex.valid & (taken | idex.is_jump); // Also flushes IF/ID and ID/EX
    assign redirect_pc = idex.is_jump ? j_target : br_target;

    always_ff @(posedge clk) begin
        if (rst) begin
            exmem.valid <= 1'b0;
        end else if (run) begin
            exmem.valid      <= idex.valid;
            exmem.result     <= alu_y;
            exmem.store_data <= b_val; // SW data takes the bypassed rt
            exmem.dest       <= idex.dest;
            exmem.writes_reg <= idex.writes_reg;
            exmem.is_load    <= idex.is_load;
            exmem.is_store   <= idex.is_store;
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch_stage.sv
/* PC and IF/ID register. A fetch that is not granted leaves a bubble in IF/ID and retries
   the same PC; a redirect wins over hold and grant. */
`default_nettype none
`include "core_params.svh"

module fetch_stage import core_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         run,
    input  wire         hold, // Load-use stall from decode
    input  wire         redirect,
    input  wire word_t  redirect_pc,
    mem_port_if.requester port,
    output logic        ifid_valid,
    output word_t       ifid_insn,
    output word_t       ifid_pc4
);

    word_t pc_q;
    word_t pc_next;

    assign pc_next    = pc_q + 4;
    assign port.req   = run;
    assign port.we    = 1'b0; // Fetch never writes
    assign port.addr  = pc_q[`MEM_AW+1:2]; // Byte to word address
    assign port.wdata = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q       <= `RESET_PC;
            ifid_valid <= 1'b0;
        end else if (run) begin
            if (redirect) begin
                pc_q       <= redirect_pc;
                ifid_valid <= 1'b0; // Wrong-path fetch dropped
            end else if (!hold) begin
                if (port.gnt) begin
                    pc_q       <= pc_next;
                    ifid_valid <= 1'b1;
                    ifid_insn  <= port.rdata;
                    ifid_pc4   <= pc_next;
                end else begin
                    ifid_valid <= 1'b0; // Port taken by the memory stage
                end
            end
            // Hold keeps both PC and IF/ID
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_arbiter.sv
/* Fixed priority: loader, then data, then fetch. The loader is expected only while run is low,
   so the memory stage is never refused while the core runs. */
`default_nettype none

module mem_arbiter import core_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    mem_port_if.arbiter    fetch,
    mem_port_if.arbiter    data,
    input  wire            load_en,
    input  wire mem_addr_t load_addr,
    input  wire word_t     load_data,
    output mem_addr_t      ram_addr,
    output logic           ram_we,
    output word_t          ram_wdata,
    input  wire word_t     ram_rdata
);

    grant_e grant_d;
    grant_e grant_q; // Last cycle's owner

    always_comb begin
        if (load_en)        grant_d = GNT_LOADER;
        else if (data.req)  grant_d = GNT_DATA; // Memory stage beats fetch
        else if (fetch.req) grant_d = GNT_FETCH;
        else                grant_d = GNT_NONE;
    end

    // Steer the winner onto the RAM
    always_comb begin
        ram_addr  = fetch.addr;
        ram_we    = 1'b0;
        ram_wdata = fetch.wdata;
        case (grant_d)
            GNT_LOADER: begin
                ram_addr  = load_addr;
                ram_we    = 1'b1; // Loader only writes
                ram_wdata = load_data;
            end
            GNT_DATA: begin
                ram_addr  = data.addr;
                ram_we    = data.we;
                ram_wdata = data.wdata;
            end
            GNT_FETCH: ram_we = fetch.we;
            default: ;
        endcase
    end

    assign fetch.gnt   = (grant_d == GNT_FETCH);
    assign data.gnt    = (grant_d == GNT_DATA);
    assign fetch.rdata = ram_rdata;
    assign data.rdata  = ram_rdata;

    always_ff @(posedge clk) begin
        if (rst) grant_q <= GNT_NONE;
        else     grant_q <= grant_d;
    end

endmodule

`default_nettype wire

//--- hw/mem_port_if.sv
/* One requester's port on the shared RAM. An access completes in the cycle req and gnt are
   both high; read data is valid that same cycle, a write lands at the next edge. */
`default_nettype none

interface mem_port_if import core_pkg::*;;

    logic      req;
    logic      we;
    mem_addr_t addr; // Word address
    word_t     wdata;
    word_t     rdata;
    logic      gnt;

    modport requester (
        output req, we, addr, wdata,
        input  rdata, gnt
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, gnt
    );

endinterface

`default_nettype wire

//--- hw/mem_wb_stage.sv
/* Data access and commit. Word accesses only, address bits [1:0] are ignored;
   the data grant is assumed whenever run is high */
`default_nettype none
`include "core_params.svh"

module mem_wb_stage import core_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          run,
    input  wire ex_mem_t exmem,
    mem_port_if.requester port,
    output mem_wb_t      wb,
    output logic         commit_valid,
    output reg_idx_t     commit_reg,
    output word_t        commit_data
);

    assign port.req   = run & exmem.valid & (exmem.is_load | exmem.is_store);
    assign port.we    = exmem.is_store;
    assign port.addr  = exmem.result[`MEM_AW+1:2];
    assign port.wdata = exmem.store_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else if (run) begin
            wb.valid      <= exmem.valid;
            wb.wdata      <= exmem.is_load ? port.rdata : exmem.result; // Same-cycle read
            wb.dest       <= exmem.dest;
            wb.writes_reg <= exmem.writes_reg;
        end
    end

    // Same condition as the register file write in decode
    assign commit_valid = run & wb.valid & wb.writes_reg & (wb.dest != '0);
    assign commit_reg   = wb.dest;
    assign commit_data  = wb.wdata;

endmodule

`default_nettype wire

//--- hw/unified_ram.sv
/* Single-port word RAM holding code and data. Read is combinational, write at the edge,
   contents are not cleared by reset */
`default_nettype none
`include "core_params.svh"

module unified_ram import core_pkg::*; (
    input  wire            clk,
    input  wire mem_addr_t addr,
    input  wire            we,
    input  wire word_t     wdata,
    output word_t          rdata
);

    word_t mem [`MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata; // Lands at this edge
        end
    end

    assign rdata = mem[addr]; // Same-cycle read

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f all.f --top-module core_tb -o core_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/core_tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "$out" | grep -qx "test passed" || exit 1
exit 0

//--- tests/core_sva.sv
/* Bound twice, to the arbiter and to decode. Inputs that do not apply at a bind site
   are tied off there. */
`default_nettype none

module core_sva import core_pkg::*; (
    input wire         clk,
    input wire         rst,
    input wire         run,
    input wire         fetch_gnt,
    input wire         data_gnt,
    input wire         data_req, // Memory stage wants the port
    input wire grant_e grant_q, // Last cycle's owner
    input wire         hold,
    input wire         commit // Register file write, same condition as commit_valid
);

    // One owner at a time, and the memory stage is never refused
    a_one_owner: assert property (@(posedge clk)
        $onehot0({fetch_gnt, data_gnt}) && (!data_req || data_gnt))
        else $error("memory grant conflict or refused memory-stage access");

    a_load_held: assert property (@(posedge clk) disable iff (rst)
        (grant_q == GNT_LOADER) |-> !data_req) // Core is held while the loader writes
        else $error("memory-stage access right after a loader write");

    ////////////////////
    // Stall and reset
    ////////////////////
    a_hold_once: assert property (@(posedge clk) disable iff (rst)
        (run && hold) |=> !hold) // Bubble clears the load in execute
        else $error("load-use hold lasted more than one cycle");

    a_reset_quiet: assert property (@(posedge clk)
        rst |-> !commit) // No register write while in reset
        else $error("register commit during reset");

endmodule

bind mem_arbiter core_sva arb_sva (
    .clk(clk), .rst(rst), .run(1'b0), .fetch_gnt(fetch.gnt), .data_gnt(data.gnt),
    .data_req(data.req), .grant_q(grant_q), .hold(1'b0), .commit(1'b0)
);

bind decode_stage core_sva dec_sva (
    .clk(clk), .rst(rst), .run(run), .fetch_gnt(1'b0), .data_gnt(1'b0), .data_req(1'b0),
    .grant_q(core_pkg::GNT_NONE), .hold(hold), .commit(rf_we)
);

`default_nettype wire

//--- tests/core_tb.sv
/* Runs five small programs, each ending in a J to itself, and checks the commit trace
   against an ISA model. Memory outside a program holds an address-based fill. */
`default_nettype none
`include "core_params.svh"

module core_tb import core_pkg::*; ();

    localparam logic [5:0] OP_ADDIU = 6'h09, OP_ORI = 6'h0d, OP_LW = 6'h23;
    localparam logic [5:0] OP_SW = 6'h2b, OP_BEQ = 6'h04, OP_BNE = 6'h05;
    localparam logic [5:0] F_ADDU = 6'h21, F_SUBU = 6'h23, F_AND = 6'h24;
    localparam logic [5:0] F_OR = 6'h25, F_SLT = 6'h2a;

    logic      clk, rst, run, load_en;
    mem_addr_t load_addr;
    word_t     load_data;
    logic      commit_valid;
    reg_idx_t  commit_reg;
    word_t     commit_data;

    word_t       image [`MEM_DEPTH]; // Program and data as loaded
    int          prog_len;
    logic [31:0] lfsr_q = 32'h8645;
    reg_idx_t    exp_reg [$];
    word_t       exp_val [$];
    int          got_cnt;
    int          errors = 0;
    int          checks = 0;

    core_top core_top_i (
        .clk(clk), .rst(rst), .run(run), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .commit_valid(commit_valid), .commit_reg(commit_reg),
        .commit_data(commit_data)
    );

    always #5 clk = ~clk;

    ////////////////////
    // Stimulus helpers
    ////////////////////
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]; // Taps 32 22 2 1
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_word(int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[30:0], lfsr_bit()}; // One step per bit
        return r;
    endfunction

    task automatic clear_image();
        for (int a = 0; a < `MEM_DEPTH; a++) begin
            image[a[7:0]] = {8'hd0, a[7:0], 8'h5a, ~a[7:0]}; // Fill tracks the address
        end
        prog_len = 0;
    endtask

    task automatic emit(word_t w);
        image[prog_len[7:0]] = w;
        prog_len++;
    endtask

    task automatic emit_r(logic [5:0] funct, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
        emit({6'h00, rs, rt, rd, 5'd0, funct});
    endtask

    task automatic emit_i(logic [5:0] op, reg_idx_t rt, reg_idx_t rs, logic [15:0] imm);
        emit({op, rs, rt, imm});
    endtask

    task automatic emit_j(logic [25:0] word_idx);
        emit({6'h02, word_idx});
    endtask

    task automatic emit_halt();
        emit_j(prog_len[25:0]); // Jump to itself
    endtask

    ////////////////////
    // ISA model
    ////////////////////
    function automatic int model_run();
        word_t       regs [32];
        word_t       dmem [`MEM_DEPTH];
        word_t       pc, npc, insn, sext, res, addr;
        logic [5:0]  op, funct;
        reg_idx_t    rs, rt, dst;
        logic        wr, done;
        int          steps;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int a = 0; a < `MEM_DEPTH; a++) dmem[a] = image[a];
        exp_reg.delete();
        exp_val.delete();
        pc = `RESET_PC;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 2000) begin
            insn  = dmem[pc[`MEM_AW+1:2]];
            op    = insn[31:26];
            funct = insn[5:0];
            rs    = insn[25:21];
            rt    = insn[20:16];
            sext  = {{16{insn[15]}}, insn[15:0]};
            addr  = regs[rs] + sext;
            npc   = pc + 32'd4;
            wr    = 1'b0;
            dst   = rt;
            res   = '0;
            case (op)
                6'h00: begin
                    dst = insn[15:11];
                    wr  = 1'b1;
                    case (funct)
                        F_ADDU:  res = regs[rs] + regs[rt];
                        F_SUBU:  res = regs[rs] - regs[rt];
                        F_AND:   res = regs[rs] & regs[rt];
                        F_OR:    res = regs[rs] | regs[rt];
                        F_SLT:   res = ($signed(regs[rs]) < $signed(regs[rt])) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: begin
                    res = regs[rs] + sext;
                    wr  = 1'b1;
                end
                OP_ORI: begin
                    res = regs[rs] | {16'h0000, insn[15:0]};
                    wr  = 1'b1;
                end
                OP_LW: begin
                    res = dmem[addr[`MEM_AW+1:2]];
                    wr  = 1'b1;
                end
                OP_SW:    dmem[addr[`MEM_AW+1:2]] = regs[rt];
                OP_BEQ:   if (regs[rs] == regs[rt]) npc = pc + 32'd4 + {sext[29:0], 2'b00};
                OP_BNE:   if (regs[rs] != regs[rt]) npc = pc + 32'd4 + {sext[29:0], 2'b00};
                6'h02: begin
                    npc  = {npc[31:28], insn[25:0], 2'b00};
                    done = (npc == pc); // Halt loop
                end
                default: ;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                exp_reg.push_back(dst);
                exp_val.push_back(res);
            end
            pc = npc;
            steps++;
        end
        return exp_reg.size();
    endfunction

    ////////////////////
    // Checking
    ////////////////////
    task automatic check_value(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Each commit against the next model entry
    always @(posedge clk) begin
        if (rst) begin
            got_cnt <= 0;
        end else if (commit_valid) begin
            if (got_cnt < exp_reg.size()) begin
                check_value("commit_reg", {27'd0, commit_reg}, {27'd0, exp_reg[got_cnt]});
                check_value("commit_data", commit_data, exp_val[got_cnt]);
            end else begin
                $display("Extra commit to r%0d at %0t beyond the model trace", commit_reg, $time);
                errors++;
            end
            got_cnt <= got_cnt + 1;
        end
    end

    task automatic run_program(string name);
        int n_exp;
        int err0;
        int timer;
        n_exp = model_run();
        err0  = errors;
        @(posedge clk);
        rst <= 1'b1;
        run <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int a = 0; a < `MEM_DEPTH; a++) begin // Loader writes the whole RAM
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= a[7:0];
            load_data <= image[a];
        end
        @(posedge clk);
        load_en <= 1'b0;
        run     <= 1'b1;
        timer = 0;
        while (got_cnt < n_exp && timer < 2000) begin
            @(posedge clk);
            timer++;
        end
        if (got_cnt < n_exp) begin
            $display("Timeout in %s after %0d of %0d commits", name, got_cnt, n_exp);
            errors++;
        end else begin
            timer = 0;
            while (timer < 20) begin // Catch commits past the trace
                @(posedge clk);
                timer++;
            end
        end
        run <= 1'b0;
        @(posedge clk);
        $display("%s: %0d commits, %s", name, n_exp, (errors == err0) ? "ok" : "mismatch");
    endtask

    ////////////////////
    // Programs
    ////////////////////
    task automatic build_arith();
        word_t r1, r2;
        clear_image();
        for (int i = 0; i < 4; i++) image[200 + i] = rand_word(32);
        image[203] = image[203] | 32'h8000_0000; // One negative operand for SLT
        emit_i(OP_LW, 5'd1, 5'd0, 16'd800);
        emit_i(OP_LW, 5'd2, 5'd0, 16'd804);
        emit_i(OP_LW, 5'd3, 5'd0, 16'd808);
        emit_i(OP_LW, 5'd4, 5'd0, 16'd812);
        emit_r(F_ADDU, 5'd5, 5'd1, 5'd2);
        emit_r(F_SUBU, 5'd6, 5'd1, 5'd2);
        emit_r(F_AND, 5'd7, 5'd3, 5'd4);
        emit_r(F_OR, 5'd8, 5'd3, 5'd4);
        emit_r(F_SLT, 5'd9, 5'd1, 5'd4);
        emit_r(F_SLT, 5'd10, 5'd4, 5'd1);
        emit_r(F_SLT, 5'd11, 5'd3, 5'd3);
        r1 = rand_word(16);
        r2 = rand_word(16);
        emit_i(OP_ADDIU, 5'd12, 5'd3, r1[15:0]);
        emit_i(OP_ORI, 5'd13, 5'd4, r2[15:0]);
        emit_i(OP_ADDIU, 5'd14, 5'd0, 16'hfffb); // Negative immediate
        emit_r(F_SLT, 5'd15, 5'd14, 5'd0);
        emit_r(F_SUBU, 5'd16, 5'd0, 5'd1);
        emit_halt();
    endtask

    task automatic build_deps();
        word_t a, b;
        clear_image();
        a = rand_word(16);
        b = rand_word(16);
        emit_i(OP_ORI, 5'd1, 5'd0, a[15:0]);
        emit_i(OP_ADDIU, 5'd2, 5'd1, b[15:0]); // Distance one
        emit_r(F_SUBU, 5'd3, 5'd2, 5'd1); // Distances one and two
        emit_r(F_OR, 5'd4, 5'd1, 5'd3); // r1 at distance three
        emit_r(F_AND, 5'd5, 5'd2, 5'd4);
        emit_r(F_ADDU, 5'd6, 5'd5, 5'd3);
        emit_r(F_SLT, 5'd7, 5'd6, 5'd2);
        emit_r(F_ADDU, 5'd7, 5'd7, 5'd6);
        emit_halt();
    endtask

    task automatic build_mem();
        word_t a;
        clear_image();
        a = rand_word(16);
        emit_i(OP_ORI, 5'd1, 5'd0, a[15:0]);
        emit_i(OP_ADDIU, 5'd2, 5'd0, 16'd1008); // Word 252
        emit_i(OP_SW, 5'd1, 5'd2, 16'd0);
        emit_i(OP_LW, 5'd3, 5'd2, 16'd0);
        emit_r(F_ADDU, 5'd4, 5'd3, 5'd3); // Load-use
        emit_i(OP_SW, 5'd4, 5'd2, 16'd4);
        emit_i(OP_LW, 5'd5, 5'd2, 16'd4);
        emit_r(F_SUBU, 5'd6, 5'd5, 5'd1);
        emit_i(OP_LW, 5'd7, 5'd2, 16'hfffc); // Fill word below
        emit_r(F_ADDU, 5'd8, 5'd7, 5'd5);
        emit_halt();
    endtask

    task automatic build_branch();
        clear_image();
        emit_i(OP_ORI, 5'd1, 5'd0, 16'd5);
        emit_i(OP_ORI, 5'd2, 5'd0, 16'd5);
        emit_i(OP_ORI, 5'd3, 5'd0, 16'd7);
        emit_i(OP_BEQ, 5'd2, 5'd1, 16'd2); // Taken, skips two
        emit_i(OP_ORI, 5'd10, 5'd0, 16'd1);
        emit_i(OP_ORI, 5'd11, 5'd0, 16'd2);
        emit_i(OP_ADDIU, 5'd4, 5'd0, 16'd1);
        emit_i(OP_BNE, 5'd3, 5'd1, 16'd1); // Taken
        emit_i(OP_ORI, 5'd12, 5'd0, 16'd3);
        emit_i(OP_BEQ, 5'd3, 5'd1, 16'd1); // Not taken
        emit_i(OP_ORI, 5'd5, 5'd0, 16'd9);
        emit_i(OP_BNE, 5'd2, 5'd1, 16'd1); // Not taken
        emit_i(OP_ORI, 5'd6, 5'd0, 16'd6);
        emit_j(26'd16);
        emit_i(OP_ORI, 5'd13, 5'd0, 16'd4);
        emit_i(OP_ORI, 5'd14, 5'd0, 16'd5);
        emit_i(OP_ADDIU, 5'd7, 5'd0, 16'd3);
        emit_i(OP_ADDIU, 5'd8, 5'd0, 16'd3);
        emit_i(OP_ADDIU, 5'd8, 5'd8, 16'hffff); // Loop body
        emit_i(OP_BNE, 5'd0, 5'd8, 16'hfffe); // Back two words
        emit_r(F_ADDU, 5'd9, 5'd8, 5'd7);
        emit_halt();
    endtask

    task automatic build_preload();
        clear_image();
        for (int i = 0; i < 8; i++) image[240 + i] = rand_word(32);
        for (int i = 0; i < 8; i++) begin
            emit_i(OP_LW, 5'(i + 1), 5'd0, 16'(960 + 4 * i));
        end
        emit_r(F_ADDU, 5'd9, 5'd1, 5'd2);
        emit_r(F_SUBU, 5'd10, 5'd3, 5'd4);
        emit_r(F_OR, 5'd11, 5'd5, 5'd6);
        emit_r(F_AND, 5'd12, 5'd7, 5'd8);
        emit_i(OP_LW, 5'd13, 5'd0, 16'd400); // Fill word 100
        emit_r(F_ADDU, 5'd14, 5'd13, 5'd9);
        emit_halt();
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        build_arith();
        run_program("arith");
        build_deps();
        run_program("bypass");
        build_mem();
        run_program("store_load");
        build_branch();
        run_program("branch");
        build_preload();
        run_program("preload");
        $display("5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
